// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tbMipsCore -f filelist.f --Mdir obj_dir -o simv
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage
(
    input logic clk,
    input logic reset,
    input pipelinePkg::instrWord instrD,
    input logic [pipelinePkg::dataWidth-1:0] pcPlus4D,
    hazardBus.decode hz,
    input logic [pipelinePkg::regAddrWidth-1:0] wbAddr,
    input logic [pipelinePkg::dataWidth-1:0] wbData,
    input logic wbEnable,
    output logic redirect,
    output logic [pipelinePkg::dataWidth-1:0] redirectPc,
    execBus.source ex
);
    import pipelinePkg::*;

    logic [dataWidth-1:0] regs [2**regAddrWidth];
    logic [dataWidth-1:0] rdA;
    logic [dataWidth-1:0] rdB;
    logic [dataWidth-1:0] immExt;
    logic [dataWidth-1:0] cmpA;
    logic [dataWidth-1:0] cmpB;
    logic [dataWidth-1:0] branchTarget;
    logic [dataWidth-1:0] jumpTarget;
    logic [5:0] opcode;
    logic [regAddrWidth-1:0] dest;
    aluOp aluCtrl;
    logic rType;
    logic regWrite;
    logic memWrite;
    logic memToReg;
    logic aluSrc;
    logic branch;
    logic jump;
    logic halt;

    ////////////////////////////////////////
    // control decode
    assign opcode = instrD.rFields.opcode;
    assign rType = opcode == opRtype;
    assign regWrite = rType | (opcode == opLw) | (opcode == opAddi) | (opcode == opOri)
                      | (opcode == opLui);
    assign memWrite = opcode == opSw;
    assign memToReg = opcode == opLw;
    assign aluSrc = !rType && (opcode != opBeq);
    assign branch = opcode == opBeq;
    assign jump = opcode == opJ;
    assign halt = opcode == opHalt;
    assign dest = rType ? instrD.rFields.rd : instrD.rFields.rt;

    always_comb
    begin
        aluCtrl = aluAdd;   // lw, sw, addi
        if (rType)
        begin
            case (instrD.rFields.funct)
                fnSub: aluCtrl = aluSub;
                fnAnd: aluCtrl = aluAnd;
                fnOr: aluCtrl = aluOr;
                fnSlt: aluCtrl = aluSlt;
                default: aluCtrl = aluAdd;
            endcase
        end
        else if (opcode == opOri)
            aluCtrl = aluOr;
        else if (opcode == opLui)
            aluCtrl = aluLui;
    end

    ////////////////////////////////////////
    // register file with writeback bypass on read
    always_ff @(posedge clk)
    begin
        if (wbEnable && wbAddr != '0)
            regs[wbAddr] <= wbData;
    end

    function automatic logic [dataWidth-1:0] readReg(input logic [regAddrWidth-1:0] idx);
        if (idx == '0)
            return '0;
        if (wbEnable && wbAddr == idx)
            return wbData;
        return regs[idx];
    endfunction

    always_comb
    begin
        rdA = readReg(instrD.rFields.rs);
        rdB = readReg(instrD.rFields.rt);
    end

    assign immExt = (opcode == opOri) ? {16'h0, instrD.iFields.imm16}
                                      : {{16{instrD.iFields.imm16[15]}}, instrD.iFields.imm16};

    // branch resolved here
    assign cmpA = hz.fwdBranchA ? hz.aluResultM : rdA;
    assign cmpB = hz.fwdBranchB ? hz.aluResultM : rdB;
    assign branchTarget = pcPlus4D + {immExt[dataWidth-3:0], 2'b00};
    assign jumpTarget = {pcPlus4D[31:28], instrD.rFields.rs, instrD.rFields.rt,
                         instrD.rFields.rd, instrD.rFields.shamt, instrD.rFields.funct, 2'b00};
    assign redirect = !hz.stall && (jump || (branch && cmpA == cmpB));
    assign redirectPc = jump ? jumpTarget : branchTarget;

    assign hz.rsD = instrD.rFields.rs;
    assign hz.rtD = instrD.rFields.rt;
    assign hz.rtUsedD = rType | branch | memWrite;
    assign hz.branchD = branch;
    assign hz.haltD = halt;

    ////////////////////////////////////////
    // decode/execute register
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            ex.aluCtrl <= aluAnd;
            ex.aluSrc <= 1'b0;
            ex.regWrite <= 1'b0;
            ex.memWrite <= 1'b0;
            ex.memToReg <= 1'b0;
            ex.halt <= 1'b0;
        end
        else
        begin
            ex.aluCtrl <= aluCtrl;
            ex.aluSrc <= aluSrc;
            ex.regWrite <= regWrite & !hz.flushExec;   // bubble on stall
            ex.memWrite <= memWrite & !hz.flushExec;
            ex.memToReg <= memToReg & !hz.flushExec;
            ex.halt <= halt & !hz.flushExec;
        end
    end

    always_ff @(posedge clk)
    begin
        ex.opA <= rdA;
        ex.opB <= rdB;
        ex.imm <= immExt;
        ex.rs <= instrD.rFields.rs;
        ex.rt <= instrD.rFields.rt;
        ex.dest <= dest;
    end
endmodule

// File: executeStage.sv
`timescale 1ns/1ps

module executeStage
(
    input logic clk,
    input logic reset,
    execBus.sink ex,
    hazardBus.execute hz,
    input logic [pipelinePkg::dataWidth-1:0] wbData,
    memBus.source mem
);
    import pipelinePkg::*;

    logic [dataWidth-1:0] srcA;
    logic [dataWidth-1:0] fwdOpB;
    logic [dataWidth-1:0] srcB;
    logic [dataWidth-1:0] aluResult;

    function automatic logic [dataWidth-1:0] pickOperand(input fwdSel sel,
                                                         input logic [dataWidth-1:0] regValue,
                                                         input logic [dataWidth-1:0] memValue,
                                                         input logic [dataWidth-1:0] wbValue);
        case (sel)
            fwdMemory: return memValue;
            fwdWriteback: return wbValue;
            default: return regValue;
        endcase
    endfunction

    assign srcA = pickOperand(hz.fwdA, ex.opA, hz.aluResultM, wbData);
    assign fwdOpB = pickOperand(hz.fwdB, ex.opB, hz.aluResultM, wbData);
    assign srcB = ex.aluSrc ? ex.imm : fwdOpB;

    always_comb
    begin
        case (ex.aluCtrl)
            aluAnd: aluResult = srcA & srcB;
            aluOr: aluResult = srcA | srcB;
            aluAdd: aluResult = srcA + srcB;
            aluSub: aluResult = srcA - srcB;
            aluSlt: aluResult = ($signed(srcA) < $signed(srcB)) ? dataWidth'(1) : '0;
            aluLui: aluResult = {srcB[15:0], 16'h0};   // immediate to upper half
            default: aluResult = '0;
        endcase
    end

    assign hz.rsE = ex.rs;
    assign hz.rtE = ex.rt;
    assign hz.destE = ex.dest;
    assign hz.regWriteE = ex.regWrite;
    assign hz.memToRegE = ex.memToReg;

    // execute/memory register
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            mem.regWrite <= 1'b0;
            mem.memWrite <= 1'b0;
            mem.memToReg <= 1'b0;
            mem.halt <= 1'b0;
        end
        else
        begin
            mem.regWrite <= ex.regWrite;
            mem.memWrite <= ex.memWrite;
            mem.memToReg <= ex.memToReg;
            mem.halt <= ex.halt;
        end
    end

    always_ff @(posedge clk)
    begin
        mem.aluResult <= aluResult;
        mem.storeData <= fwdOpB;   // store data after forwarding
        mem.dest <= ex.dest;
    end
endmodule

// File: fetchStage.sv
`timescale 1ns/1ps

module fetchStage
(
    input logic clk,
    input logic reset,
    hazardBus.fetch hz,
    input logic redirect,
    input logic [pipelinePkg::dataWidth-1:0] redirectPc,
    output logic [pipelinePkg::dataWidth-1:0] imemAddr,
    input logic [pipelinePkg::dataWidth-1:0] imemData,
    output pipelinePkg::instrWord instrD,
    output logic [pipelinePkg::dataWidth-1:0] pcPlus4D
);
    import pipelinePkg::*;

    logic [dataWidth-1:0] pc;
    logic [dataWidth-1:0] pcPlus4;

    assign imemAddr = pc;
    assign pcPlus4 = pc + dataWidth'(4);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            pc <= resetPc;
            instrD <= '0;
        end
        else if (!hz.stall)
        begin
            if (redirect)
            begin
                pc <= redirectPc;
                instrD <= '0;   // squash the slot behind a taken branch
            end
            else
            begin
                pc <= pcPlus4;
                instrD <= imemData;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!hz.stall)
            pcPlus4D <= pcPlus4;
    end
endmodule

// File: filelist.f
pipelinePkg.sv
pipelineIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
mipsCore.sv
mipsCore_chk.sv
tbMipsCore.sv

// File: hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit
(
    hazardBus.hazard hz
);
    import pipelinePkg::*;

    logic loadUse;
    logic branchWaitAlu;
    logic branchWaitLoad;
    logic dataStall;

    // a live write to a nonzero register that matches the source
    function automatic logic hits(input logic [regAddrWidth-1:0] src,
                                  input logic [regAddrWidth-1:0] dest,
                                  input logic enable);
        return enable && src != '0 && src == dest;
    endfunction

    ////////////////////////////////////////
    // execute forwarding, memory stage first
    assign hz.fwdA = hits(hz.rsE, hz.destM, hz.regWriteM) ? fwdMemory
                   : hits(hz.rsE, hz.destW, hz.regWriteW) ? fwdWriteback : fwdNone;
    assign hz.fwdB = hits(hz.rtE, hz.destM, hz.regWriteM) ? fwdMemory
                   : hits(hz.rtE, hz.destW, hz.regWriteW) ? fwdWriteback : fwdNone;

    // branch compare in decode
    assign hz.fwdBranchA = hits(hz.rsD, hz.destM, hz.regWriteM);
    assign hz.fwdBranchB = hits(hz.rtD, hz.destM, hz.regWriteM);

    ////////////////////////////////////////
    // stalls
    assign loadUse = hits(hz.rsD, hz.destE, hz.memToRegE)
                     || (hz.rtUsedD && hits(hz.rtD, hz.destE, hz.memToRegE));
    assign branchWaitAlu = hz.branchD && (hits(hz.rsD, hz.destE, hz.regWriteE)
                                          || hits(hz.rtD, hz.destE, hz.regWriteE));
    // load result only exists after memory stage
    assign branchWaitLoad = hz.branchD && (hits(hz.rsD, hz.destM, hz.memToRegM)
                                           || hits(hz.rtD, hz.destM, hz.memToRegM));
    assign dataStall = loadUse || branchWaitAlu || branchWaitLoad;

    assign hz.stall = dataStall || hz.haltD;   // halt freezes fetch
    assign hz.flushExec = dataStall;
endmodule

// File: memoryStage.sv
`timescale 1ns/1ps

module memoryStage
(
    input logic clk,
    input logic reset,
    memBus.sink mem,
    hazardBus.memory hz,
    output logic [pipelinePkg::dataWidth-1:0] dmemAddr,
    output logic [pipelinePkg::dataWidth-1:0] dmemWriteData,
    output logic dmemWriteEnable,
    input logic [pipelinePkg::dataWidth-1:0] dmemReadData,
    output logic [pipelinePkg::regAddrWidth-1:0] wbAddr,
    output logic [pipelinePkg::dataWidth-1:0] wbData,
    output logic wbEnable,
    output logic halted
);
    import pipelinePkg::*;

    logic [dataWidth-1:0] aluResultW;
    logic [dataWidth-1:0] readDataW;
    logic memToRegW;
    logic haltW;

    // data port, memory reads combinationally
    assign dmemAddr = mem.aluResult;
    assign dmemWriteData = mem.storeData;
    assign dmemWriteEnable = mem.memWrite;

    assign hz.destM = mem.dest;
    assign hz.regWriteM = mem.regWrite;
    assign hz.memToRegM = mem.memToReg;
    assign hz.aluResultM = mem.aluResult;
    assign hz.destW = wbAddr;
    assign hz.regWriteW = wbEnable;

    ////////////////////////////////////////
    // memory/writeback register
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            wbEnable <= 1'b0;
            memToRegW <= 1'b0;
            haltW <= 1'b0;
            halted <= 1'b0;
        end
        else
        begin
            wbEnable <= mem.regWrite;
            memToRegW <= mem.memToReg;
            haltW <= mem.halt;
            if (haltW)
                halted <= 1'b1;   // sticky until reset
        end
    end

    always_ff @(posedge clk)
    begin
        aluResultW <= mem.aluResult;
        readDataW <= dmemReadData;
        wbAddr <= mem.dest;
    end

    assign wbData = memToRegW ? readDataW : aluResultW;
endmodule

// File: mipsCore.sv
`timescale 1ns/1ps

module mipsCore
(
    input logic clk,
    input logic reset,
    output logic [pipelinePkg::dataWidth-1:0] imemAddr,
    input logic [pipelinePkg::dataWidth-1:0] imemData,
    output logic [pipelinePkg::dataWidth-1:0] dmemAddr,
    output logic [pipelinePkg::dataWidth-1:0] dmemWriteData,
    output logic dmemWriteEnable,
    input logic [pipelinePkg::dataWidth-1:0] dmemReadData,
    output logic halted
);
    import pipelinePkg::*;

    instrWord instrD;
    logic [dataWidth-1:0] pcPlus4D;
    logic redirect;
    logic [dataWidth-1:0] redirectPc;
    logic [regAddrWidth-1:0] wbAddr;
    logic [dataWidth-1:0] wbData;
    logic wbEnable;

    execBus exLink ();
    memBus memLink ();
    hazardBus hzLink ();

    fetchStage stageFetch (.clk, .reset, .hz(hzLink), .redirect, .redirectPc,
                           .imemAddr, .imemData, .instrD, .pcPlus4D);

    decodeStage stageDecode (.clk, .reset, .instrD, .pcPlus4D, .hz(hzLink),
                             .wbAddr, .wbData, .wbEnable, .redirect, .redirectPc,
                             .ex(exLink));

    executeStage stageExecute (.clk, .reset, .ex(exLink), .hz(hzLink), .wbData,
                               .mem(memLink));

    memoryStage stageMemory (.clk, .reset, .mem(memLink), .hz(hzLink),
                             .dmemAddr, .dmemWriteData, .dmemWriteEnable, .dmemReadData,
                             .wbAddr, .wbData, .wbEnable, .halted);

    hazardUnit hazardCtl (.hz(hzLink));
endmodule

// File: mipsCore_chk.sv
`timescale 1ns/1ps

module mipsCore_chk
(
    input logic clk,
    input logic reset,
    input logic [pipelinePkg::dataWidth-1:0] imemAddr,
    input logic dmemWriteEnable,
    input logic halted
);
    // a stopped core leaves memory alone
    noStoreWhileHalted: assert property (@(posedge clk) disable iff (reset)
                                         !(dmemWriteEnable && halted))
        else $error("store enable high while the core is halted");

    alignedFetch: assert property (@(posedge clk) disable iff (reset)
                                   imemAddr[1:0] == 2'b00)
        else $error("fetch address not word-aligned");

    haltedSticky: assert property (@(posedge clk) disable iff (reset)
                                   halted |=> halted)   // only reset clears it
        else $error("halted fell without reset");
endmodule

// File: pipelineIf.sv
`timescale 1ns/1ps

// decode/execute register contents
interface execBus;
    import pipelinePkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] imm;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] dest;
    aluOp aluCtrl;
    logic aluSrc;      // immediate as second operand
    logic regWrite;
    logic memWrite;
    logic memToReg;
    logic halt;

    modport source (output opA, opB, imm, rs, rt, dest, aluCtrl, aluSrc,
                    regWrite, memWrite, memToReg, halt);
    modport sink (input opA, opB, imm, rs, rt, dest, aluCtrl, aluSrc,
                  regWrite, memWrite, memToReg, halt);
endinterface

// execute/memory register contents
interface memBus;
    import pipelinePkg::*;

    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] storeData;
    logic [regAddrWidth-1:0] dest;
    logic regWrite;
    logic memWrite;
    logic memToReg;
    logic halt;

    modport source (output aluResult, storeData, dest, regWrite, memWrite, memToReg, halt);
    modport sink (input aluResult, storeData, dest, regWrite, memWrite, memToReg, halt);
endinterface

interface hazardBus;
    import pipelinePkg::*;

    logic [regAddrWidth-1:0] rsD;
    logic [regAddrWidth-1:0] rtD;
    logic rtUsedD;     // rt is a source, not a destination
    logic branchD;
    logic haltD;
    logic [regAddrWidth-1:0] rsE;
    logic [regAddrWidth-1:0] rtE;
    logic [regAddrWidth-1:0] destE;
    logic regWriteE;
    logic memToRegE;
    logic [regAddrWidth-1:0] destM;
    logic regWriteM;
    logic memToRegM;
    logic [dataWidth-1:0] aluResultM;
    logic [regAddrWidth-1:0] destW;
    logic regWriteW;
    logic stall;
    logic flushExec;
    fwdSel fwdA;
    fwdSel fwdB;
    logic fwdBranchA;
    logic fwdBranchB;

    modport fetch (input stall);
    modport decode (output rsD, rtD, rtUsedD, branchD, haltD,
                    input stall, flushExec, fwdBranchA, fwdBranchB, aluResultM);
    modport execute (output rsE, rtE, destE, regWriteE, memToRegE,
                     input fwdA, fwdB, aluResultM);
    modport memory (output destM, regWriteM, memToRegM, aluResultM, destW, regWriteW);
    modport hazard (input rsD, rtD, rtUsedD, branchD, haltD, rsE, rtE, destE, regWriteE,
                    memToRegE, destM, regWriteM, memToRegM, destW, regWriteW,
                    output stall, flushExec, fwdA, fwdB, fwdBranchA, fwdBranchB);
endinterface

// File: pipelinePkg.sv
package pipelinePkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam logic [dataWidth-1:0] resetPc = 32'h0040_0000;

    ////////////////////////////////////////
    // opcodes
    localparam logic [5:0] opRtype = 6'b000000;
    localparam logic [5:0] opLw    = 6'b100011;
    localparam logic [5:0] opSw    = 6'b101011;
    localparam logic [5:0] opBeq   = 6'b000100;
    localparam logic [5:0] opJ     = 6'b000010;
    localparam logic [5:0] opAddi  = 6'b001000;
    localparam logic [5:0] opOri   = 6'b001101;
    localparam logic [5:0] opLui   = 6'b001111;
    localparam logic [5:0] opHalt  = 6'b001110;

    // function field of R-type
    localparam logic [5:0] fnAdd = 6'b100000;
    localparam logic [5:0] fnSub = 6'b100010;
    localparam logic [5:0] fnAnd = 6'b100100;
    localparam logic [5:0] fnOr  = 6'b100101;
    localparam logic [5:0] fnSlt = 6'b101010;

    typedef enum logic [2:0] {aluAnd, aluOr, aluAdd, aluSub, aluSlt, aluLui} aluOp;

    // operand source in execute and decode
    typedef enum logic [1:0] {fwdNone, fwdWriteback, fwdMemory} fwdSel;

    typedef union packed
    {
        struct packed
        {
            logic [5:0] opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [regAddrWidth-1:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFields;
        struct packed
        {
            logic [5:0] opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;
            logic [15:0] imm16;
        } iFields;
    } instrWord;

endpackage

// File: tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore;
    import pipelinePkg::*;

    localparam int prologueLen = 31;
    localparam int bodyLen = 60;
    localparam int bodyEnd = prologueLen + bodyLen;   // first epilogue slot
    localparam int progLen = bodyEnd + 32;            // 31 stores and the halt
    localparam int cycleLimit = 6 * progLen + 100;
    localparam logic [31:0] lfsrTaps = 32'h8020_0003;

    logic clk;
    logic reset;
    logic [dataWidth-1:0] imemAddr;
    logic [dataWidth-1:0] imemData;
    logic [dataWidth-1:0] dmemAddr;
    logic [dataWidth-1:0] dmemWriteData;
    logic dmemWriteEnable;
    logic [dataWidth-1:0] dmemReadData;
    logic halted;

    instrWord romWords [128];
    logic [dataWidth-1:0] dataMem [128];
    logic [dataWidth-1:0] modelMem [128];
    logic [dataWidth-1:0] modelRegs [32];
    logic [dataWidth-1:0] expAddrQ [$];
    logic [dataWidth-1:0] expDataQ [$];
    logic [dataWidth-1:0] fetchOffset;
    logic [31:0] lfsrState;
    int storeCount;
    int cycleCount;
    logic sawHalted;

    mipsCore uut (.clk, .reset, .imemAddr, .imemData, .dmemAddr, .dmemWriteData,
                  .dmemWriteEnable, .dmemReadData, .halted);

    bind mipsCore mipsCore_chk coreChecks (.clk(clk), .reset(reset), .imemAddr(imemAddr),
                                           .dmemWriteEnable(dmemWriteEnable),
                                           .halted(halted));

    always #5 clk = ~clk;

    ////////////////////////////////////////
    // failure reporting and compares
    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic checkWord(input string testName, input logic [dataWidth-1:0] expected,
                             input logic [dataWidth-1:0] actual);
        if (actual !== expected)
            reportFailure($sformatf("Error: %s expected 0x%08h actual 0x%08h",
                                    testName, expected, actual));
    endtask

    task automatic checkFlag(input string testName, input logic expected, input logic actual);
        if (actual !== expected)
            reportFailure($sformatf("Error: %s expected %b actual %b",
                                    testName, expected, actual));
    endtask

    // galois lfsr, one step per bit
    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        logic outBit;
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            outBit = lfsrState[0];
            lfsrState = (lfsrState >> 1) ^ (outBit ? lfsrTaps : 32'h0);
            bits = {bits[30:0], outBit};
        end
        return bits;
    endfunction

    function automatic logic [dataWidth-1:0] fillWord(input int idx);
        return 32'h5a00_0000 ^ (32'(idx) * 32'h0103_0507);
    endfunction

    function automatic instrWord rInstr(input logic [5:0] funct, input logic [4:0] rd,
                                        input logic [4:0] rs, input logic [4:0] rt);
        instrWord w;
        w.rFields.opcode = opRtype;
        w.rFields.rs = rs;
        w.rFields.rt = rt;
        w.rFields.rd = rd;
        w.rFields.shamt = 5'd0;
        w.rFields.funct = funct;
        return w;
    endfunction

    function automatic instrWord iInstr(input logic [5:0] opcode, input logic [4:0] rt,
                                        input logic [4:0] rs, input logic [15:0] imm);
        instrWord w;
        w.iFields.opcode = opcode;
        w.iFields.rs = rs;
        w.iFields.rt = rt;
        w.iFields.imm16 = imm;
        return w;
    endfunction

    ////////////////////////////////////////
    // random program, forward control flow only
    task automatic buildProgram();
        logic [3:0] kind;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [15:0] imm;
        logic [dataWidth-1:0] target;
        int skip;
        for (int r = 1; r < 32; r++)
            romWords[7'(r - 1)] = iInstr(opAddi, 5'(r), 5'd0, 16'(takeBits(16)));
        for (int i = prologueLen; i < bodyEnd; i++)
        begin
            kind = 4'(takeBits(4));
            rd = 5'(takeBits(3));   // r0..r7 keeps hazards frequent
            rs = 5'(takeBits(3));
            rt = 5'(takeBits(3));
            imm = 16'(takeBits(16));
            skip = int'(takeBits(2));
            if (skip > bodyEnd - 1 - i)
                skip = bodyEnd - 1 - i;
            case (kind)
                4'd0, 4'd1: romWords[7'(i)] = rInstr(fnAdd, rd, rs, rt);
                4'd2: romWords[7'(i)] = rInstr(fnSub, rd, rs, rt);
                4'd3: romWords[7'(i)] = rInstr(fnAnd, rd, rs, rt);
                4'd4: romWords[7'(i)] = rInstr(fnOr, rd, rs, rt);
                4'd5: romWords[7'(i)] = rInstr(fnSlt, rd, rs, rt);
                4'd6: romWords[7'(i)] = iInstr(opAddi, rt, rs, imm);
                4'd7: romWords[7'(i)] = iInstr(opOri, rt, rs, imm);
                4'd8: romWords[7'(i)] = iInstr(opLui, rt, 5'd0, imm);
                4'd9, 4'd10: romWords[7'(i)] = iInstr(opLw, rt, 5'd0, {8'h0, imm[5:0], 2'b00});
                4'd11, 4'd12: romWords[7'(i)] = iInstr(opSw, rt, 5'd0, {8'h0, imm[5:0], 2'b00});
                4'd13, 4'd14:
                begin
                    if (imm[15])
                        rt = rs;   // equal operands, always taken
                    romWords[7'(i)] = iInstr(opBeq, rt, rs, 16'(skip));
                end
                default:
                begin
                    target = resetPc + dataWidth'(4 * (i + 1 + skip));
                    romWords[7'(i)] = {opJ, target[27:2]};
                end
            endcase
        end
        for (int r = 1; r < 32; r++)
            romWords[7'(bodyEnd + r - 1)] = iInstr(opSw, 5'(r), 5'd0, 16'(16'h100 + 4 * r));
        romWords[7'(progLen - 1)] = iInstr(opHalt, 5'd0, 5'd0, 16'h0);
    endtask

    ////////////////////////////////////////
    // sequential ISA model
    task automatic runModel();
        instrWord w;
        logic [31:0] raw;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic [dataWidth-1:0] immS;
        logic [dataWidth-1:0] result;
        logic [dataWidth-1:0] addr;
        int pcIdx;
        int steps;
        logic done;
        for (int k = 0; k < 32; k++)
            modelRegs[5'(k)] = '0;
        pcIdx = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4 * progLen)
        begin
            w = romWords[7'(pcIdx)];
            raw = w;
            a = modelRegs[w.iFields.rs];
            b = modelRegs[w.iFields.rt];
            immS = {{16{w.iFields.imm16[15]}}, w.iFields.imm16};
            addr = a + immS;
            result = '0;
            pcIdx = pcIdx + 1;
            steps = steps + 1;
            case (w.rFields.opcode)
                opRtype:
                begin
                    case (w.rFields.funct)
                        fnAdd: result = a + b;
                        fnSub: result = a - b;
                        fnAnd: result = a & b;
                        fnOr: result = a | b;
                        fnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: result = '0;
                    endcase
                    if (w.rFields.rd != 5'd0)
                        modelRegs[w.rFields.rd] = result;
                end
                opAddi, opOri, opLui, opLw:
                begin
                    if (w.rFields.opcode == opAddi)
                        result = addr;
                    else if (w.rFields.opcode == opOri)
                        result = a | {16'h0, w.iFields.imm16};
                    else if (w.rFields.opcode == opLui)
                        result = {w.iFields.imm16, 16'h0};
                    else
                        result = modelMem[addr[8:2]];
                    if (w.iFields.rt != 5'd0)
                        modelRegs[w.iFields.rt] = result;
                end
                opSw:
                begin
                    modelMem[addr[8:2]] = b;
                    expAddrQ.push_back(addr);
                    expDataQ.push_back(b);
                end
                opBeq:
                begin
                    if (a == b)
                        pcIdx = pcIdx + int'($signed(immS));
                end
                opJ:
                begin
                    addr = resetPc + dataWidth'(4 * pcIdx);
                    addr = {addr[31:28], raw[25:0], 2'b00};
                    pcIdx = int'((addr - resetPc) >> 2);
                end
                opHalt: done = 1'b1;
                default: ;
            endcase
        end
        if (!done)
            reportFailure("the ISA model never reached the halt instruction");
    endtask

    ////////////////////////////////////////
    // memory models
    assign fetchOffset = (imemAddr - resetPc) >> 2;
    assign imemData = (fetchOffset < dataWidth'(progLen)) ? romWords[fetchOffset[6:0]] : '0;
    assign dmemReadData = dataMem[dmemAddr[8:2]];

    // store monitor and data memory writes
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (imemAddr[1:0] != 2'b00)
                reportFailure("the fetch address is not word-aligned");
            if (sawHalted && !halted)
                reportFailure("halted fell without a reset");
            if (dmemWriteEnable)
            begin
                if (halted)
                    reportFailure("a store appeared after halted rose");
                if (storeCount >= expAddrQ.size())
                    reportFailure("the core made more stores than the ISA model");
                checkWord("store address", expAddrQ[storeCount], dmemAddr);
                checkWord("store data", expDataQ[storeCount], dmemWriteData);
                storeCount = storeCount + 1;
                dataMem[dmemAddr[8:2]] <= dmemWriteData;
            end
            if (halted)
                sawHalted = 1'b1;
        end
    end

    always @(posedge clk)
    begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
            reportFailure($sformatf("Timeout: the core did not halt within %0d cycles",
                                    cycleLimit));
    end

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        lfsrState = 32'h884e;
        storeCount = 0;
        cycleCount = 0;
        sawHalted = 1'b0;
        for (int k = 0; k < 128; k++)
        begin
            dataMem[7'(k)] <= fillWord(k);
            modelMem[7'(k)] = fillWord(k);
            romWords[7'(k)] = '0;
        end
        buildProgram();
        runModel();

        repeat (10) @(posedge clk);
        checkFlag("reset dmemWriteEnable", 1'b0, dmemWriteEnable);
        checkFlag("reset halted", 1'b0, halted);
        checkWord("reset imemAddr", resetPc, imemAddr);
        reset <= 1'b0;

        while (!halted)
            @(posedge clk);
        repeat (20)
        begin
            @(posedge clk);
            checkFlag("halted stays high", 1'b1, halted);
        end
        checkWord("store count", dataWidth'(expAddrQ.size()), dataWidth'(storeCount));
        $display("All checks passed");
        $finish;
    end
endmodule
